//--- reset_consts.svh
/* Reset and boot subsystem constants
   Bus widths, hold tap and reset vector defaults, synchronizer depth */

`ifndef RESET_CONSTS_SVH
`define RESET_CONSTS_SVH

// Instruction bus and reset vector width
`define VEC_W 16

// Hold tap select width, hold length is 2**tap ticks of clk3
`define TAP_W 3

// Tap loaded by arst_n, 3 gives 8 ticks
`define HOLD_TAP_DEFAULT 3'd3

// Vector loaded by arst_n
// High byte all ones, low byte F0
`define RESET_VECTOR_DEFAULT 16'hFFF0

// Depth of the reset request synchronizer
`define SYNC_STAGES 2

`endif

//--- reset_pkg.sv
/* Reset and boot subsystem types
   Boot sequencer states and configuration register addresses */

package reset_pkg;

   ////////////////////////////////////////////////////////////////////////
   // Boot sequencer states
   ////////////////////////////////////////////////////////////////////////

   // HOLD   core held in reset, vector on the bus
   // FETCH  hold released, first fetch requested
   // RUN    first fetch accepted, core running
   typedef enum logic [1:0] {
      HOLD  = 2'd0,
      FETCH = 2'd1,
      RUN   = 2'd2
   } boot_state_e;

   ////////////////////////////////////////////////////////////////////////
   // Configuration register map
   ////////////////////////////////////////////////////////////////////////

   // STATUS is read only
   // SW_RESET reads as zero, a write fires a reset request
   typedef enum logic [1:0] {
      HOLD_TAP = 2'd0,
      VECTOR   = 2'd1,
      STATUS   = 2'd2,
      SW_RESET = 2'd3
   } cfg_reg_e;

endpackage

//--- reset_cfg_if.sv
/* Configuration link from the register block to timer and sequencer */

`timescale 1ns/10ps

`include "reset_consts.svh"

interface reset_cfg_if;

   // Selected hold length as a power of two
   logic [`TAP_W-1:0]      hold_tap;
   // Vector driven on ibus while the core is held
   logic [`VEC_W-1:0]      vector;
   // One-cycle software reset request
   logic                   sw_reset;
   // Sequencer state, read back through STATUS
   reset_pkg::boot_state_e boot_state;

   // Register block side
   modport regs (
      output hold_tap,
      output vector,
      output sw_reset,
      input  boot_state
   );

   // Hold timer only needs the tap and the software kick
   modport timer (
      input hold_tap,
      input sw_reset
   );

   // Boot sequencer side
   modport seq (
      input  vector,
      output boot_state
   );

endinterface

//--- reset_sync.sv
/* Reset request synchronizer
   Merges front panel, power-good and software sources into one request */

`timescale 1ns/10ps

`include "reset_consts.svh"

module reset_sync (
   input  logic clk3,
   input  logic arst_n,
   input  logic fp_reset_n,
   input  logic power_ok,
   input  logic sw_reset,
   output logic reset_req
);

   localparam int STAGES = `SYNC_STAGES;

   // Flop chain, stage STAGES-1 is the request
   logic [STAGES-1:0] sync_q;
   // External sources that need synchronizing
   logic              ext_active;

   // Front panel button is active low
   // Power-good low means supply not yet stable
   assign ext_active = !fp_reset_n || !power_ok;

   ////////////////////////////////////////////////////////////////////////
   // Synchronizer chain
   ////////////////////////////////////////////////////////////////////////

   // Chain presets on arst_n so the request is up at once
   // External sources enter at stage 0 and walk through
   // Software pulse is already on clk3, it sets every stage at once
   // so the request is held for the full chain depth
   always_ff @(posedge clk3 or negedge arst_n) begin
      if (!arst_n) begin
         sync_q <= '1;
      end else begin
         sync_q <= {sync_q[STAGES-2:0], ext_active} | {STAGES{sw_reset}};
      end
   end

   // Release happens STAGES cycles after the last source clears
   assign reset_req = sync_q[STAGES-1];

endmodule

//--- reset_timer.sv
/* Reset hold timer
   Counts clk3 ticks after the request drops and releases the core at the tap */

`timescale 1ns/10ps

`include "reset_consts.svh"

module reset_timer (
   input  logic       clk3,
   input  logic       arst_n,
   input  logic       reset_req,
   reset_cfg_if.timer cfg,
   output logic       rst_hold_n
);

   // One counter bit per tap position, 8 bits for a 3-bit tap
   localparam int CNT_W = 1 << `TAP_W;

   // Tick counter, cleared while the request is up
   logic [CNT_W-1:0]  tick_cnt;
   logic [CNT_W-1:0]  tick_nxt;
   // Tap captured during the request
   logic [`TAP_W-1:0] tap_q;
   // Any cause that restarts the hold
   logic              restart;

   assign tick_nxt = tick_cnt + 1'b1;

   // Software pulse is synchronous already
   // so it restarts the hold without waiting for the chain
   assign restart = reset_req || cfg.sw_reset;

   ////////////////////////////////////////////////////////////////////////
   // Hold counter
   ////////////////////////////////////////////////////////////////////////

   // Counting from zero, the selected bit first sets at 2**tap
   // Once released the counter stops until the next restart
   always_ff @(posedge clk3 or negedge arst_n) begin
      if (!arst_n) begin
         tick_cnt   <= '0;
         tap_q      <= `HOLD_TAP_DEFAULT;
         rst_hold_n <= 1'b0;
      end else if (restart) begin
         tick_cnt   <= '0;
         tap_q      <= cfg.hold_tap;
         rst_hold_n <= 1'b0;
      end else if (!rst_hold_n) begin
         tick_cnt <= tick_nxt;
         // Release in the cycle the count reaches the tap
         if (tick_nxt[tap_q]) begin
            rst_hold_n <= 1'b1;
         end
      end
   end

endmodule

//--- reset_cfg_regs.sv
/* Reset configuration registers
   Four-phase host port for hold tap, vector, status and software reset */

`timescale 1ns/10ps

`include "reset_consts.svh"

module reset_cfg_regs (
   input  logic                clk3,
   input  logic                arst_n,
   input  logic                cfg_req,
   input  logic                cfg_we,
   input  reset_pkg::cfg_reg_e cfg_addr,
   input  logic [`VEC_W-1:0]   cfg_wdata,
   output logic                cfg_ack,
   output logic [`VEC_W-1:0]   cfg_rdata,
   reset_cfg_if.regs           cfg
);

   localparam int ST_W = $bits(reset_pkg::boot_state_e);

   // Request seen but not yet acknowledged
   logic              access;
   // Programmable registers
   logic [`TAP_W-1:0] hold_tap_q;
   logic [`VEC_W-1:0] vector_q;
   // Software reset pulse
   logic              sw_reset_q;
   // Read data for the current address
   logic [`VEC_W-1:0] rd_mux;

   ////////////////////////////////////////////////////////////////////////
   // Host handshake
   ////////////////////////////////////////////////////////////////////////

   // Exactly one cycle per transfer has req high and ack low
   assign access = cfg_req && !cfg_ack;

   // Ack follows req by one cycle in both directions
   always_ff @(posedge clk3 or negedge arst_n) begin
      if (!arst_n) begin
         cfg_ack <= 1'b0;
      end else begin
         cfg_ack <= cfg_req;
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // Register writes
   ////////////////////////////////////////////////////////////////////////

   // Only arst_n restores the defaults
   // software and front panel resets leave these alone
   always_ff @(posedge clk3 or negedge arst_n) begin
      if (!arst_n) begin
         hold_tap_q <= `HOLD_TAP_DEFAULT;
         vector_q   <= `RESET_VECTOR_DEFAULT;
      end else if (access && cfg_we) begin
         case (cfg_addr)
            reset_pkg::HOLD_TAP: hold_tap_q <= cfg_wdata[`TAP_W-1:0];
            reset_pkg::VECTOR:   vector_q   <= cfg_wdata;
            default: ;
         endcase
      end
   end

   // Pulse lines up with the rising ack
   always_ff @(posedge clk3 or negedge arst_n) begin
      if (!arst_n) begin
         sw_reset_q <= 1'b0;
      end else begin
         sw_reset_q <= access && cfg_we && (cfg_addr == reset_pkg::SW_RESET);
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // Register reads
   ////////////////////////////////////////////////////////////////////////

   always_comb begin
      case (cfg_addr)
         reset_pkg::HOLD_TAP: rd_mux = {{(`VEC_W-`TAP_W){1'b0}}, hold_tap_q};
         reset_pkg::VECTOR:   rd_mux = vector_q;
         reset_pkg::STATUS:   rd_mux = {{(`VEC_W-ST_W){1'b0}}, cfg.boot_state};
         default:             rd_mux = '0;
      endcase
   end

   // Captured on the access cycle, stable while ack is high
   always_ff @(posedge clk3) begin
      if (access && !cfg_we) begin
         cfg_rdata <= rd_mux;
      end
   end

   // Configuration out to timer and sequencer
   assign cfg.hold_tap = hold_tap_q;
   assign cfg.vector   = vector_q;
   assign cfg.sw_reset = sw_reset_q;

endmodule

//--- boot_sequencer.sv
/* Boot sequencer
   Presents the reset vector, holds IR in reset and hands off to fetch */

`timescale 1ns/10ps

`include "reset_consts.svh"

module boot_sequencer (
   input  logic              clk3,
   input  logic              arst_n,
   input  logic              reset_req,
   input  logic              rst_hold_n,
   input  logic              fetch_ack,
   reset_cfg_if.seq          cfg,
   output logic              fetch_req,
   output logic              ir_rst,
   output logic              vector_oe,
   output logic [`VEC_W-1:0] ibus
);

   reset_pkg::boot_state_e state_q;
   reset_pkg::boot_state_e state_nxt;

   ////////////////////////////////////////////////////////////////////////
   // State machine
   ////////////////////////////////////////////////////////////////////////

   // A request or a dropped hold wins from any state
   // HOLD moves on once the timer lets go
   // FETCH waits for the fetch unit to latch the vector
   always_comb begin
      state_nxt = state_q;
      if (reset_req || !rst_hold_n) begin
         state_nxt = reset_pkg::HOLD;
      end else begin
         case (state_q)
            reset_pkg::HOLD: begin
               state_nxt = reset_pkg::FETCH;
            end
            reset_pkg::FETCH: begin
               if (fetch_ack) begin
                  state_nxt = reset_pkg::RUN;
               end
            end
            reset_pkg::RUN: begin
               state_nxt = reset_pkg::RUN;
            end
            default: begin
               state_nxt = reset_pkg::HOLD;
            end
         endcase
      end
   end

   always_ff @(posedge clk3 or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= reset_pkg::HOLD;
      end else begin
         state_q <= state_nxt;
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // Outputs
   ////////////////////////////////////////////////////////////////////////

   // IR reset is hold active and first fetch not yet accepted
   // so it stays up through HOLD and FETCH
   assign ir_rst    = (state_q != reset_pkg::RUN);
   assign vector_oe = (state_q != reset_pkg::RUN);

   // Request the first fetch only in FETCH
   // drops together with ir_rst on entry to RUN
   assign fetch_req = (state_q == reset_pkg::FETCH);

   // Bus driver, vector when enabled, idle low otherwise
   assign ibus = vector_oe ? cfg.vector : '0;

   // State back to the register block for STATUS
   assign cfg.boot_state = state_q;

endmodule

//--- reset_logic.sv
/* Reset and boot subsystem top level
   Wires the synchronizer, hold timer, register block and boot sequencer */

`timescale 1ns/10ps

`include "reset_consts.svh"

module reset_logic (
   input  logic                clk3,
   input  logic                arst_n,
   input  logic                fp_reset_n,
   input  logic                power_ok,
   input  logic                cfg_req,
   input  logic                cfg_we,
   input  reset_pkg::cfg_reg_e cfg_addr,
   input  logic [`VEC_W-1:0]   cfg_wdata,
   output logic                cfg_ack,
   output logic [`VEC_W-1:0]   cfg_rdata,
   input  logic                fetch_ack,
   output logic                fetch_req,
   output logic                rst_hold_n,
   output logic                ir_rst,
   output logic                vector_oe,
   output logic [`VEC_W-1:0]   ibus
);

   // Merged and synchronized reset request
   logic reset_req;

   // Configuration link between the blocks
   reset_cfg_if cfg_bus ();

   ////////////////////////////////////////////////////////////////////////
   // Reset path
   ////////////////////////////////////////////////////////////////////////

   reset_sync u_reset_sync (
      .clk3       (clk3),
      .arst_n     (arst_n),
      .fp_reset_n (fp_reset_n),
      .power_ok   (power_ok),
      .sw_reset   (cfg_bus.sw_reset),
      .reset_req  (reset_req)
   );

   reset_timer u_reset_timer (
      .clk3       (clk3),
      .arst_n     (arst_n),
      .reset_req  (reset_req),
      .cfg        (cfg_bus),
      .rst_hold_n (rst_hold_n)
   );

   ////////////////////////////////////////////////////////////////////////
   // Configuration and boot
   ////////////////////////////////////////////////////////////////////////

   reset_cfg_regs u_reset_cfg_regs (
      .clk3      (clk3),
      .arst_n    (arst_n),
      .cfg_req   (cfg_req),
      .cfg_we    (cfg_we),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg_ack   (cfg_ack),
      .cfg_rdata (cfg_rdata),
      .cfg       (cfg_bus)
   );

   boot_sequencer u_boot_sequencer (
      .clk3       (clk3),
      .arst_n     (arst_n),
      .reset_req  (reset_req),
      .rst_hold_n (rst_hold_n),
      .fetch_ack  (fetch_ack),
      .cfg        (cfg_bus),
      .fetch_req  (fetch_req),
      .ir_rst     (ir_rst),
      .vector_oe  (vector_oe),
      .ibus       (ibus)
   );

endmodule

//--- tb_reset_logic.sv
/* Testbench for the reset and boot subsystem
   Random resets, register traffic and fetch back-pressure against a model */

`timescale 1ns/10ps

`include "reset_consts.svh"

module tb_reset_logic;

   localparam int ITERS   = 6;
   // Power-up boot plus six boots or register runs per round
   localparam int N_TESTS = 1 + ITERS * 6;
   // Longest hold, sync stages, fetch delay and host traffic per test
   localparam int LIMIT   = N_TESTS * (128 + 2 + 8 + 20);

   logic                clk3;
   logic                arst_n;
   logic                fp_reset_n;
   logic                power_ok;
   logic                cfg_req;
   logic                cfg_we;
   reset_pkg::cfg_reg_e cfg_addr;
   logic [`VEC_W-1:0]   cfg_wdata;
   logic                cfg_ack;
   logic [`VEC_W-1:0]   cfg_rdata;
   logic                fetch_ack;
   logic                fetch_req;
   logic                rst_hold_n;
   logic                ir_rst;
   logic                vector_oe;
   logic [`VEC_W-1:0]   ibus;

   // Reference model of the programmable registers
   logic [`TAP_W-1:0]   model_tap;
   logic [`VEC_W-1:0]   model_vec;
   int                  cycles = 0;

   reset_logic UUT (
      .clk3       (clk3),
      .arst_n     (arst_n),
      .fp_reset_n (fp_reset_n),
      .power_ok   (power_ok),
      .cfg_req    (cfg_req),
      .cfg_we     (cfg_we),
      .cfg_addr   (cfg_addr),
      .cfg_wdata  (cfg_wdata),
      .cfg_ack    (cfg_ack),
      .cfg_rdata  (cfg_rdata),
      .fetch_ack  (fetch_ack),
      .fetch_req  (fetch_req),
      .rst_hold_n (rst_hold_n),
      .ir_rst     (ir_rst),
      .vector_oe  (vector_oe),
      .ibus       (ibus)
   );

   // 100 ns clk3
   initial clk3 = 1'b0;
   always #50 clk3 = ~clk3;

   // Run limit
   always @(posedge clk3) begin
      cycles <= cycles + 1;
      if (cycles > LIMIT) begin
         show_problem("Timeout, the run went past its cycle limit");
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Error reporting and compare tasks
   ///////////////////////////////////////////////////////////////////////

   task automatic stop_run();
      $display("ERRORS FOUND");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic show_problem(input string msg);
      $display("%s", msg);
      stop_run();
   endtask

   task automatic check_vec(input string name, input logic [`VEC_W-1:0] exp,
                            input logic [`VEC_W-1:0] act);
      if (act !== exp) begin
         $display("FAILED time %0t: %s expected %h actual %h", $time, name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("FAILED time %0t: %s expected %b actual %b", $time, name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_state(input reset_pkg::boot_state_e exp,
                              input reset_pkg::boot_state_e act);
      if (act !== exp) begin
         $display("FAILED time %0t: STATUS expected %s actual %s",
                  $time, exp.name(), act.name());
         stop_run();
      end
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Drivers
   ///////////////////////////////////////////////////////////////////////

   // Step to the drive point 5 ns after the rising edge
   task automatic next_cycle();
      @(posedge clk3);
      #5;
   endtask

   // Four-phase host transfer, ack follows each edge of req by one cycle
   task automatic host_access(input logic we, input reset_pkg::cfg_reg_e addr,
                              input logic [`VEC_W-1:0] wdata,
                              output logic [`VEC_W-1:0] rdata);
      cfg_req   = 1'b1;
      cfg_we    = we;
      cfg_addr  = addr;
      cfg_wdata = wdata;
      next_cycle();
      check_bit("cfg_ack", 1'b1, cfg_ack);
      rdata   = cfg_rdata;
      cfg_req = 1'b0;
      next_cycle();
      check_bit("cfg_ack", 1'b0, cfg_ack);
   endtask

   task automatic write_reg(input reset_pkg::cfg_reg_e addr, input logic [`VEC_W-1:0] data);
      logic [`VEC_W-1:0] unused;
      host_access(1'b1, addr, data, unused);
   endtask

   task automatic read_check(input reset_pkg::cfg_reg_e addr, input logic [`VEC_W-1:0] exp);
      logic [`VEC_W-1:0] rd;
      host_access(1'b0, addr, '0, rd);
      check_vec(addr.name(), exp, rd);
   endtask

   task automatic read_status(input reset_pkg::boot_state_e exp);
      logic [`VEC_W-1:0] rd;
      host_access(1'b0, reset_pkg::STATUS, '0, rd);
      check_state(exp, reset_pkg::boot_state_e'(rd[1:0]));
      // Bits above the state read as zero
      check_vec("STATUS high bits", '0, {2'b00, rd[`VEC_W-1:2]});
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Boot sequence model
   ///////////////////////////////////////////////////////////////////////

   // Core held, vector on the bus
   task automatic check_hold();
      check_bit("rst_hold_n", 1'b0, rst_hold_n);
      check_bit("ir_rst", 1'b1, ir_rst);
      check_bit("vector_oe", 1'b1, vector_oe);
      check_bit("fetch_req", 1'b0, fetch_req);
      check_vec("ibus", model_vec, ibus);
   endtask

   // Hold released, first fetch pending
   task automatic check_fetch_wait();
      check_bit("rst_hold_n", 1'b1, rst_hold_n);
      check_bit("fetch_req", 1'b1, fetch_req);
      check_bit("ir_rst", 1'b1, ir_rst);
      check_bit("vector_oe", 1'b1, vector_oe);
      check_vec("ibus", model_vec, ibus);
   endtask

   // Front panel or power-good pulse of random width, 3 cycles
   // is enough for the request to reach the outputs
   task automatic pulse_source(input bit use_fp);
      int width;
      width = 3 + $urandom % 8;
      if (use_fp) begin
         fp_reset_n = 1'b0;
      end else begin
         power_ok = 1'b0;
      end
      repeat (width) next_cycle();
      check_hold();
      fp_reset_n = 1'b1;
      power_ok   = 1'b1;
   endtask

   // Called at the cycle the last source clears
   // hold ends SYNC_STAGES + 2**tap cycles later
   task automatic run_boot(input bit cut_fetch);
      int hold_len;
      int delay;
      hold_len = `SYNC_STAGES + (1 << model_tap);
      for (int k = 1; k < hold_len; k++) begin
         next_cycle();
         check_hold();
      end
      next_cycle();
      check_bit("rst_hold_n", 1'b1, rst_hold_n);
      check_bit("fetch_req", 1'b0, fetch_req);
      // Sequencer leaves HOLD on the next edge
      next_cycle();
      check_fetch_wait();
      if (!cut_fetch) begin
         // Fetch unit back-pressure, 0 to 7 cycles
         delay = $urandom % 8;
         if (delay >= 2) begin
            read_status(reset_pkg::FETCH);
            delay -= 2;
         end
         for (int i = 0; i < delay; i++) begin
            next_cycle();
            check_fetch_wait();
         end
         check_fetch_wait();
         fetch_ack = 1'b1;
         next_cycle();
         // All three drop together on entry to RUN
         check_bit("fetch_req", 1'b0, fetch_req);
         check_bit("ir_rst", 1'b0, ir_rst);
         check_bit("vector_oe", 1'b0, vector_oe);
         fetch_ack = 1'b0;
         read_status(reset_pkg::RUN);
      end
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Test sequence
   ///////////////////////////////////////////////////////////////////////

   initial begin
      logic [`VEC_W-1:0] wdata;
      void'($urandom(10));
      arst_n     = 1'b0;
      fp_reset_n = 1'b1;
      power_ok   = 1'b1;
      cfg_req    = 1'b0;
      cfg_we     = 1'b0;
      cfg_addr   = reset_pkg::HOLD_TAP;
      cfg_wdata  = '0;
      fetch_ack  = 1'b0;
      model_tap  = `HOLD_TAP_DEFAULT;
      model_vec  = `RESET_VECTOR_DEFAULT;
      repeat (10) next_cycle();
      check_hold();
      check_bit("cfg_ack", 1'b0, cfg_ack);
      check_vec("ibus", 16'hFFF0, ibus);
      arst_n = 1'b1;
      run_boot(1'b0);
      read_check(reset_pkg::HOLD_TAP, 16'd3);
      read_check(reset_pkg::VECTOR, 16'hFFF0);
      for (int i = 0; i < ITERS; i++) begin
         // Register round trip, only the tap bits stick
         wdata = $urandom;
         write_reg(reset_pkg::HOLD_TAP, wdata);
         model_tap = wdata[`TAP_W-1:0];
         model_vec = $urandom;
         write_reg(reset_pkg::VECTOR, model_vec);
         read_check(reset_pkg::HOLD_TAP, {{(`VEC_W-`TAP_W){1'b0}}, model_tap});
         read_check(reset_pkg::VECTOR, model_vec);
         read_status(reset_pkg::RUN);
         pulse_source(1'b1);
         run_boot(1'b0);
         pulse_source(1'b0);
         run_boot(1'b0);
         // Software reset keeps the registers
         write_reg(reset_pkg::SW_RESET, $urandom);
         run_boot(1'b0);
         read_check(reset_pkg::HOLD_TAP, {{(`VEC_W-`TAP_W){1'b0}}, model_tap});
         read_check(reset_pkg::VECTOR, model_vec);
         read_check(reset_pkg::SW_RESET, '0);
         // Front panel reset while the first fetch waits
         pulse_source(1'b1);
         run_boot(1'b1);
         pulse_source(1'b1);
         run_boot(1'b0);
      end
      $display("NO ERRORS");
      $finish;
   end

endmodule

//--- list.f
+incdir+.
reset_pkg.sv
reset_cfg_if.sv
reset_sync.sv
reset_timer.sv
reset_cfg_regs.sv
boot_sequencer.sv
reset_logic.sv
tb_reset_logic.sv
